/* com_tx/com_crc16.sv */
`timescale 1ns/1ps

module com_crc16 (
    input  logic               clk,
    input  logic               clear,
    input  logic               enable,
    input  com_pkg::com_data_t din,
    output logic [15:0]        crc
);
    // x^16 + x^15 + x^2 + 1
    localparam logic [15:0] POLY = 16'h8005;

    logic [15:0] rem;
    logic [15:0] rem_next;

    // One byte per cycle, MSB first
    always_comb begin
        rem_next = rem;
        for (int i = 7; i >= 0; i--) begin
            if (rem_next[15] ^ din[i]) begin
                rem_next = {rem_next[14:0], 1'b0} ^ POLY;
            end else begin
                rem_next = {rem_next[14:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            rem <= '1;
        end else if (enable) begin
            rem <= rem_next;
        end
    end

    assign crc = ~rem;

endmodule

/* com_tx/com_crc5.sv */
`timescale 1ns/1ps

module com_crc5 (
    input  logic               clk,
    input  logic               clear,
    input  logic               enable,
    input  com_pkg::com_data_t din,
    output com_pkg::com_data_t crc
);
    // x^5 + x^2 + 1
    localparam logic [4:0] POLY = 5'h05;

    logic [4:0] rem;
    logic [4:0] rem_next;

    // One byte per cycle, MSB first
    always_comb begin
        rem_next = rem;
        for (int i = 7; i >= 0; i--) begin
            if (rem_next[4] ^ din[i]) begin
                rem_next = {rem_next[3:0], 1'b0} ^ POLY;
            end else begin
                rem_next = {rem_next[3:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            rem <= '1;
        end else if (enable) begin
            rem <= rem_next;
        end
    end

    assign crc = {3'b000, ~rem};

endmodule

/* com_tx/com_tx.sv */
`timescale 1ns/1ps
`include "com_settings.svh"

module com_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fs,
    output logic                 fd,
    input  com_pkg::com_addr_t   ram_addr_init,
    input  com_pkg::com_len_t    tx_dlen,
    input  com_pkg::com_btype_t  btype,
    input  com_pkg::com_data_t   ram_rxd,
    output com_pkg::com_addr_t   ram_rxa,
    output com_pkg::com_stream_t tx
);
    import com_pkg::*;

    localparam int LAT = `COM_RAM_LATENCY;

    // Count in DONE at which fd rises one cycle after the last line byte
    localparam com_len_t DONE_HOLD = 2;

    localparam logic [1:0] SEL_BYTE = 2'd0;
    localparam logic [1:0] SEL_CRC5 = 2'd1;
    localparam logic [1:0] SEL_C16H = 2'd2;
    localparam logic [1:0] SEL_C16L = 2'd3;

    typedef enum logic [3:0] {
        IDLE,
        WAIT,
        SYNC,
        WPID,
        DNUM,
        WORK,
        CRC5,
        CRC16,
        DONE
    } state_t;

    state_t      state;
    state_t      next_state;
    com_len_t    num;
    com_addr_t   rd_off;
    logic        rd_step;
    com_pid_t    pid;
    logic        is_stat;
    logic        is_data;
    com_stream_t txb;
    logic [1:0]  txb_sel;
    logic        txb_pay;
    logic        crc_clear;
    com_data_t   crc5_out;
    logic [15:0] crc16_out;

    // PID and packet tail from the type code; unknown codes give a zero PID
    always_comb begin
        pid = '0;
        is_stat = 1'b0;
        is_data = 1'b0;
        case (btype)
            BTYPE_ACK: pid = PID_ACK;
            BTYPE_NAK: pid = PID_NAK;
            BTYPE_STL: pid = PID_STL;
            BTYPE_DLINK, BTYPE_DTYPE, BTYPE_DTEMP: begin
                pid = PID_STAT;
                is_stat = 1'b1;
            end
            BTYPE_DATA0: begin
                pid = PID_DATA0;
                is_data = 1'b1;
            end
            BTYPE_DATA1: begin
                pid = PID_DATA1;
                is_data = 1'b1;
            end
            default: pid = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: if (fs) next_state = SYNC;
            SYNC: next_state = WPID;
            WPID: next_state = (is_stat || is_data) ? DNUM : DONE;
            DNUM: if (num == com_len_t'(1)) next_state = WORK;
            WORK: begin
                if (num == tx_dlen - com_len_t'(1)) begin
                    next_state = is_stat ? CRC5 : CRC16;
                end
            end
            CRC5: next_state = DONE;
            CRC16: if (num == com_len_t'(1)) next_state = DONE;
            DONE: if (num == DONE_HOLD && !fs) next_state = WAIT;
            default: next_state = IDLE;
        endcase
    end

    // Byte counter restarts on every state change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (next_state != state) begin
            num <= '0;
        end else if (state inside {DNUM, WORK, CRC16} ||
                     (state == DONE && num != DONE_HOLD)) begin
            num <= num + 1'b1;
        end
    end

    assign fd = (state == DONE) && (num == DONE_HOLD);

    // Reads run LAT cycles ahead of WORK
    // First payload byte sits 4 cycles after SYNC
    assign rd_step = (state == SYNC && LAT >= 4) ||
                     (state == WPID && LAT >= 3) ||
                     (state == DNUM && num + LAT >= 2) ||
                     (state == WORK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_off <= '0;
        end else if (state == WAIT) begin
            rd_off <= '0;
        end else if (rd_step) begin
            rd_off <= rd_off + 1'b1;
        end
    end

    // Wraps modulo the buffer size
    assign ram_rxa = ram_addr_init + rd_off;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txb <= '0;
            txb_sel <= SEL_BYTE;
            txb_pay <= 1'b0;
        end else begin
            txb.valid <= 1'b1;
            txb.data <= '0;
            txb_sel <= SEL_BYTE;
            txb_pay <= 1'b0;
            case (state)
                SYNC: txb.data <= PID_SYNC;
                WPID: txb.data <= pid;
                DNUM: txb.data <= (num == '0) ? {4'h0, tx_dlen[11:8]} : tx_dlen[7:0];
                WORK: begin
                    txb.data <= ram_rxd;
                    txb_pay <= 1'b1;
                end
                CRC5: txb_sel <= SEL_CRC5;
                CRC16: txb_sel <= (num == '0) ? SEL_C16H : SEL_C16L;
                default: txb.valid <= 1'b0;
            endcase
        end
    end

    // CRC results are ready one cycle after the last payload byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx <= '0;
        end else begin
            tx.valid <= txb.valid;
            case (txb_sel)
                SEL_CRC5: tx.data <= crc5_out;
                SEL_C16H: tx.data <= crc16_out[15:8];
                SEL_C16L: tx.data <= crc16_out[7:0];
                default:  tx.data <= txb.data;
            endcase
        end
    end

    assign crc_clear = (state == WAIT);

    com_crc5 u_crc5 (
        .clk    (clk),
        .clear  (crc_clear),
        .enable (txb_pay),
        .din    (txb.data),
        .crc    (crc5_out)
    );

    com_crc16 u_crc16 (
        .clk    (clk),
        .clear  (crc_clear),
        .enable (txb_pay),
        .din    (txb.data),
        .crc    (crc16_out)
    );

endmodule

/* common/com_pkg.sv */
`include "com_settings.svh"

package com_pkg;

    typedef logic [`COM_ADDR_W-1:0] com_addr_t;
    typedef logic [`COM_ADDR_W-1:0] com_len_t;
    typedef logic [7:0]             com_data_t;
    typedef logic [3:0]             com_btype_t;
    typedef logic [7:0]             com_pid_t;

    // Handshake types
    localparam com_btype_t BTYPE_ACK   = 4'd1;
    localparam com_btype_t BTYPE_NAK   = 4'd2;
    localparam com_btype_t BTYPE_STL   = 4'd3;
    // Status types, closed by CRC5
    localparam com_btype_t BTYPE_DLINK = 4'd8;
    localparam com_btype_t BTYPE_DTYPE = 4'd9;
    localparam com_btype_t BTYPE_DTEMP = 4'd10;
    // Data types, closed by CRC16
    localparam com_btype_t BTYPE_DATA0 = 4'd13;
    localparam com_btype_t BTYPE_DATA1 = 4'd14;

    localparam com_pid_t PID_SYNC  = 8'h0F;
    localparam com_pid_t PID_ACK   = 8'h2D;
    localparam com_pid_t PID_NAK   = 8'hA5;
    localparam com_pid_t PID_STL   = 8'hE1;
    localparam com_pid_t PID_STAT  = 8'hD2;
    localparam com_pid_t PID_DATA0 = 8'h96;
    localparam com_pid_t PID_DATA1 = 8'h5A;

    // Line byte stream, one byte per clock
    typedef struct packed {
        logic      valid;
        com_data_t data;
    } com_stream_t;

    // Host write into the packet buffer
    typedef struct packed {
        logic      en;
        com_addr_t addr;
        com_data_t data;
    } com_wr_t;

endpackage

/* common/com_settings.svh */
`ifndef COM_SETTINGS_SVH
`define COM_SETTINGS_SVH

// Buffer address and payload length width
`define COM_ADDR_W 12

// Cycles from read address to read data (1 to 3)
`define COM_RAM_LATENCY 2

`endif

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_com_tx -o sim_tb_com_tx
./obj_dir/sim_tb_com_tx

/* test/tb_com_tx.sv */
`timescale 1ns/1ps
`include "com_settings.svh"

module tb_com_tx;
    import com_pkg::*;

    localparam int DEPTH    = 1 << `COM_ADDR_W;
    localparam int MAX_WAIT = 6000;

    logic        clk = 1'b0;
    logic        rst;
    com_wr_t     wr;
    logic        fs;
    logic        fd;
    com_addr_t   ram_addr_init;
    com_len_t    tx_dlen;
    com_btype_t  btype;
    com_stream_t tx;

    integer    seed;
    com_data_t mem_model [0:DEPTH-1];
    com_data_t exp_q [$];

    com_tx_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .wr            (wr),
        .fs            (fs),
        .fd            (fd),
        .ram_addr_init (ram_addr_init),
        .tx_dlen       (tx_dlen),
        .btype         (btype),
        .tx            (tx)
    );

    always #10 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        assert (cond) else begin
            $display("ERROR time=%0t: %s", $time, msg);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // Bit-serial MSB-first CRC models over the payload in the buffer model
    function automatic logic [4:0] crc5_model(input com_addr_t addr, input com_len_t len);
        logic [4:0] r;
        logic       fb;
        com_data_t  b;
        r = 5'h1F;
        for (int i = 0; i < len; i++) begin
            b = mem_model[com_addr_t'(addr + i)];
            for (int k = 7; k >= 0; k--) begin
                fb = r[4] ^ b[k];
                r = {r[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
            end
        end
        return ~r;
    endfunction

    function automatic logic [15:0] crc16_model(input com_addr_t addr, input com_len_t len);
        logic [15:0] r;
        logic        fb;
        com_data_t   b;
        r = 16'hFFFF;
        for (int i = 0; i < len; i++) begin
            b = mem_model[com_addr_t'(addr + i)];
            for (int k = 7; k >= 0; k--) begin
                fb = r[15] ^ b[k];
                r = {r[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
            end
        end
        return ~r;
    endfunction

    function automatic void build_expected(input com_btype_t bt, input com_addr_t addr,
                                           input com_len_t len);
        com_pid_t    pid;
        int          kind;
        logic [15:0] c16;
        pid = 8'h00;
        kind = 0;
        case (bt)
            BTYPE_ACK: pid = PID_ACK;
            BTYPE_NAK: pid = PID_NAK;
            BTYPE_STL: pid = PID_STL;
            BTYPE_DLINK, BTYPE_DTYPE, BTYPE_DTEMP: begin
                pid = PID_STAT;
                kind = 1;
            end
            BTYPE_DATA0: begin
                pid = PID_DATA0;
                kind = 2;
            end
            BTYPE_DATA1: begin
                pid = PID_DATA1;
                kind = 2;
            end
            default: pid = 8'h00;
        endcase
        exp_q.delete();
        exp_q.push_back(PID_SYNC);
        exp_q.push_back(pid);
        if (kind != 0) begin
            exp_q.push_back({4'h0, len[11:8]});
            exp_q.push_back(len[7:0]);
            for (int i = 0; i < len; i++) begin
                exp_q.push_back(mem_model[com_addr_t'(addr + i)]);
            end
        end
        if (kind == 1) begin
            exp_q.push_back({3'b000, crc5_model(addr, len)});
        end else if (kind == 2) begin
            c16 = crc16_model(addr, len);
            exp_q.push_back(c16[15:8]);
            exp_q.push_back(c16[7:0]);
        end
    endfunction

    // Fills the payload, sends one packet and checks every byte as it arrives
    task automatic send_packet(input com_btype_t bt, input com_addr_t addr,
                               input com_len_t len, input int hold);
        int   rnd;
        int   cycles;
        int   got;
        int   last_cycle;
        logic gap;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            wr.en = 1'b1;
            wr.addr = com_addr_t'(addr + i);
            wr.data = rnd[7:0];
            mem_model[wr.addr] = rnd[7:0];
            step();
        end
        wr.en = 1'b0;
        build_expected(bt, addr, len);
        btype = bt;
        ram_addr_init = addr;
        tx_dlen = len;
        fs = 1'b1;
        cycles = 0;
        got = 0;
        last_cycle = 0;
        gap = 1'b0;
        while (!fd) begin
            step();
            cycles++;
            require(cycles <= MAX_WAIT, "timed out waiting for fd after fs was raised");
            if (tx.valid) begin
                require(got != 0 || cycles == 3, "SYNC did not start 2 cycles after fs");
                require(!gap, "valid dropped between two bytes of one packet");
                require(got < exp_q.size(), "packet has more bytes than expected");
                check_value($sformatf("tx.data[%0d]", got), exp_q[got], tx.data);
                got++;
                last_cycle = cycles;
            end else if (got != 0) begin
                gap = 1'b1;
            end
        end
        check_value("tx.valid", 0, tx.valid);
        check_value("packet byte count", exp_q.size(), got);
        check_value("fd rise cycle", last_cycle + 1, cycles);
        // fd must hold while fs stays high
        for (int k = 0; k < hold; k++) begin
            step();
            check_value("fd", 1, fd);
            check_value("tx.valid", 0, tx.valid);
        end
        fs = 1'b0;
        cycles = 0;
        while (fd) begin
            step();
            cycles++;
            require(cycles <= 4, "timed out waiting for fd to drop after fs went low");
            check_value("tx.valid", 0, tx.valid);
        end
        check_value("fd fall cycle", 1, cycles);
    endtask

    task automatic reset_values();
        check_value("fd", 0, fd);
        check_value("tx.valid", 0, tx.valid);
        check_value("tx.data", 0, tx.data);
        check_value("ram_rxa", ram_addr_init, u_dut.rd_addr);
    endtask

    task automatic handshake_packets();
        send_packet(BTYPE_ACK, 12'd0, 12'd0, 0);
        send_packet(BTYPE_NAK, 12'd0, 12'd0, 0);
        send_packet(BTYPE_STL, 12'd0, 12'd0, 0);
    endtask

    task automatic data_packets();
        send_packet(BTYPE_DATA0, 12'd100, 12'd16, 0);
        send_packet(BTYPE_DATA1, 12'd7, 12'd1, 0);
    endtask

    task automatic status_packets();
        send_packet(BTYPE_DLINK, 12'd200, 12'd3, 0);
        send_packet(BTYPE_DLINK, 12'd500, 12'd300, 0);
        send_packet(BTYPE_DTYPE, 12'd210, 12'd3, 0);
        send_packet(BTYPE_DTYPE, 12'd900, 12'd300, 0);
        send_packet(BTYPE_DTEMP, 12'd220, 12'd3, 0);
        send_packet(BTYPE_DTEMP, 12'd1300, 12'd300, 0);
    endtask

    task automatic address_wrap();
        send_packet(BTYPE_DATA0, 12'd4090, 12'd10, 0);
    endtask

    // Same type twice in a row exposes a CRC that is not cleared
    task automatic fd_hold_and_back_to_back();
        send_packet(BTYPE_DATA1, 12'd2000, 12'd8, 6);
        send_packet(BTYPE_DATA0, 12'd2100, 12'd20, 0);
        send_packet(BTYPE_DATA0, 12'd2200, 12'd20, 0);
        send_packet(BTYPE_DTEMP, 12'd2300, 12'd5, 0);
        send_packet(BTYPE_DTEMP, 12'd2400, 12'd5, 0);
    endtask

    task automatic unsupported_type();
        send_packet(4'd5, 12'd3000, 12'd4, 0);
    endtask

    initial begin
        seed = 31;
        rst = 1'b1;
        wr = '0;
        fs = 1'b0;
        ram_addr_init = 12'h5A3;
        tx_dlen = '0;
        btype = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        step();
        step();
        handshake_packets();
        data_packets();
        status_packets();
        address_wrap();
        fd_hold_and_back_to_back();
        unsupported_type();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/com_pkg.sv
com_tx/com_crc5.sv
com_tx/com_crc16.sv
com_tx/com_tx.sv
verilog/tx_buffer.sv
verilog/com_tx_top.sv
test/tb_com_tx.sv

/* verilog/com_tx_top.sv */
`timescale 1ns/1ps

module com_tx_top (
    input  logic                 clk,
    input  logic                 rst,
    input  com_pkg::com_wr_t     wr,
    input  logic                 fs,
    output logic                 fd,
    input  com_pkg::com_addr_t   ram_addr_init,
    input  com_pkg::com_len_t    tx_dlen,
    input  com_pkg::com_btype_t  btype,
    output com_pkg::com_stream_t tx
);
    import com_pkg::*;

    com_addr_t rd_addr;
    com_data_t rd_data;

    // Host fills the packet buffer
    tx_buffer u_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    com_tx u_tx (
        .clk           (clk),
        .rst           (rst),
        .fs            (fs),
        .fd            (fd),
        .ram_addr_init (ram_addr_init),
        .tx_dlen       (tx_dlen),
        .btype         (btype),
        .ram_rxd       (rd_data),
        .ram_rxa       (rd_addr),
        .tx            (tx)
    );

endmodule

/* verilog/tx_buffer.sv */
`timescale 1ns/1ps
`include "com_settings.svh"

module tx_buffer (
    input  logic               clk,
    input  com_pkg::com_wr_t   wr,
    input  com_pkg::com_addr_t rd_addr,
    output com_pkg::com_data_t rd_data
);
    import com_pkg::*;

    localparam int LAT   = `COM_RAM_LATENCY;
    localparam int DEPTH = 1 << `COM_ADDR_W;

    com_data_t mem [0:DEPTH-1];
    com_addr_t addr_q;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        addr_q <= rd_addr;
    end

    // Address register counts as the first read stage
    generate
        if (LAT == 1) begin : g_lat1
            assign rd_data = mem[addr_q];
        end else begin : g_latn
            com_data_t pipe [0:LAT-2];

            always_ff @(posedge clk) begin
                pipe[0] <= mem[addr_q];
                for (int i = 1; i < LAT - 1; i++) begin
                    pipe[i] <= pipe[i-1];
                end
            end

            assign rd_data = pipe[LAT-2];
        end
    endgenerate

endmodule
